// ==== rtl/wb_consts.svh ====
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

`define WB_ADDR_W 32
`define WB_DATA_W 32
`define WB_MM_W 64
`define WB_SEL_W 16
`define WB_SIZE_W 2

// third register port always writes a doubleword
`define WB_DR3_SIZE 2'b10
// only the reserved bit 1 set
`define WB_FLAGS_RESET 32'h0000_0002

`endif

// ==== rtl/wb_pkg.sv ====
`include "wb_consts.svh"

package wb_pkg;

   // decoded control word for the micro-op in writeback
   typedef struct packed {
      logic is_halt;
      logic is_jne;
      logic is_jnbe;
      logic is_cmovc;
      logic is_cmps_first;
      logic is_cmps_second;
      logic ld_gpr3;
      logic ld_seg;
      logic ld_flags;
      logic ld_eip;
      logic ld_cs;
      logic pop_flags;
      logic push_flags;
      logic save_neip;
      logic save_ncs;
      logic use_temp_neip;
      logic use_temp_ncs;
      logic mm_mem;
      logic [2:0] dr3;
      logic [`WB_DATA_W-1:0] flags_affected;
   } uop_ctrl_t;

   // positions within the flags word
   typedef enum logic [4:0] {
      FLAG_CF = 5'd0,
      FLAG_ZF = 5'd6
   } flag_bit_e;

endpackage

// ==== rtl/wb_ctrl_if.sv ====
`include "wb_consts.svh"

interface wb_ctrl_if;
   logic commit;
   logic use_temp_neip;
   logic use_temp_ncs;
   logic take_not_taken;
   logic save_neip;
   logic save_ncs;
   logic save_count;
   logic push_flags;
   logic pop_flags;
   logic ld_flags;
   logic [`WB_DATA_W-1:0] flags_affected;
   logic zf;
   logic cf;

   modport ctrl (
      output commit, use_temp_neip, use_temp_ncs, take_not_taken, save_neip, save_ncs,
      output save_count, push_flags, pop_flags, ld_flags, flags_affected,
      input  zf, cf
   );

   modport flags (
      input  commit, pop_flags, ld_flags, flags_affected,
      output zf, cf
   );

   modport opsel (
      input commit, use_temp_neip, use_temp_ncs, take_not_taken, save_neip, save_ncs,
      input save_count, push_flags
   );
endinterface

// ==== rtl/wb_control.sv ====
`include "wb_consts.svh"

module wb_control (
   input  logic                  wb_v,
   input  wb_pkg::uop_ctrl_t     uop,
   input  logic                  ex_ld_gpr1,
   input  logic                  ex_ld_gpr2,
   input  logic                  d2_ld_mm,
   input  logic                  ex_dcache_write,
   input  logic                  d2_repne,
   input  logic [2:0]            dr1,
   input  logic [2:0]            dr2,
   input  logic [`WB_DATA_W-1:0] result_c,
   input  logic                  store_done,
   output logic                  store_req,
   output logic                  stall,
   output logic [2:0]            final_dr1,
   output logic [2:0]            final_dr2,
   output logic                  ld_gpr1,
   output logic                  ld_gpr2,
   output logic                  ld_gpr3,
   output logic                  ld_seg,
   output logic                  ld_mm,
   output logic                  ld_eip,
   output logic                  ld_cs,
   output logic                  ld_flags,
   output logic                  dep_ld_gpr1,
   output logic                  dep_ld_gpr2,
   output logic                  dep_ld_gpr3,
   output logic                  dep_ld_seg,
   output logic                  dep_ld_mm,
   output logic                  dep_dcache_write,
   output logic                  halt,
   output logic                  repne_terminate,
   output logic                  branch_taken,
   wb_ctrl_if.ctrl               ctl
);
   logic commit;
   logic jne_taken;
   logic jnbe_taken;

   assign store_req = wb_v & ex_dcache_write;
   assign stall = store_req & ~store_done;
   // nothing architectural moves until the store has completed
   assign commit = wb_v & ~stall;

   assign jne_taken = ~ctl.zf;
   assign jnbe_taken = ~ctl.cf & ~ctl.zf;
   assign branch_taken = wb_v & ((uop.is_jne & jne_taken) | (uop.is_jnbe & jnbe_taken));

   assign halt = wb_v & uop.is_halt;
   assign repne_terminate = wb_v & uop.is_cmps_second & d2_repne &
                            (ctl.zf | (result_c == '0));

   // cmps second uop writes its pointers in swapped order
   assign final_dr1 = uop.is_cmps_second ? dr2 : dr1;
   assign final_dr2 = uop.is_cmps_second ? dr1 : dr2;

   assign dep_ld_gpr1 = wb_v & ex_ld_gpr1 & ~repne_terminate;
   assign dep_ld_gpr2 = wb_v & ex_ld_gpr2 & (~uop.is_cmovc | ctl.cf) & ~repne_terminate;
   assign dep_ld_gpr3 = wb_v & uop.ld_gpr3;
   assign dep_ld_seg = wb_v & uop.ld_seg;
   assign dep_ld_mm = wb_v & d2_ld_mm;
   assign dep_dcache_write = store_req;

   assign ld_gpr1 = dep_ld_gpr1 & commit;
   assign ld_gpr2 = dep_ld_gpr2 & commit;
   assign ld_gpr3 = dep_ld_gpr3 & commit;
   assign ld_seg = dep_ld_seg & commit;
   assign ld_mm = dep_ld_mm & commit;
   assign ld_eip = uop.ld_eip & commit;
   assign ld_cs = uop.ld_cs & commit;
   assign ld_flags = uop.ld_flags & commit;

   assign ctl.commit = commit;
   assign ctl.ld_flags = ld_flags;
   assign ctl.pop_flags = uop.pop_flags;
   assign ctl.push_flags = uop.push_flags;
   assign ctl.flags_affected = uop.flags_affected;
   assign ctl.use_temp_neip = uop.use_temp_neip;
   assign ctl.use_temp_ncs = uop.use_temp_ncs;
   assign ctl.save_neip = uop.save_neip;
   assign ctl.save_ncs = uop.save_ncs;
   assign ctl.save_count = uop.is_cmps_first;
   // a conditional jump that falls through resumes at the next sequential eip
   assign ctl.take_not_taken = (uop.is_jne & ~jne_taken) | (uop.is_jnbe & ~jnbe_taken);
endmodule

// ==== rtl/wb_flags_unit.sv ====
`include "wb_consts.svh"

module wb_flags_unit (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [`WB_DATA_W-1:0] flags_in,
   input  logic [`WB_DATA_W-1:0] result_a,
   output logic [`WB_DATA_W-1:0] flags_fwd,
   wb_ctrl_if.flags              ctl
);
   logic [`WB_DATA_W-1:0] flags_q;
   logic [`WB_DATA_W-1:0] merged;
   logic [`WB_DATA_W-1:0] flags_next;

   // only the affected bits come from execute
   assign merged = (flags_in & ctl.flags_affected) | (flags_q & ~ctl.flags_affected);

   always_comb begin
      if (!ctl.ld_flags) begin
         flags_next = flags_q;
      end else if (ctl.pop_flags) begin
         flags_next = result_a;
      end else begin
         flags_next = merged;
      end
   end

   assign flags_fwd = flags_next;
   assign ctl.zf = flags_next[wb_pkg::FLAG_ZF];
   assign ctl.cf = flags_next[wb_pkg::FLAG_CF];

   always_ff @(posedge clk) begin
      if (reset) begin
         flags_q <= `WB_FLAGS_RESET;
      end else if (ctl.commit) begin
         flags_q <= flags_next;
      end
   end
endmodule

// ==== rtl/wb_operand_select.sv ====
`include "wb_consts.svh"

module wb_operand_select (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [`WB_DATA_W-1:0] result_a,
   input  logic [`WB_DATA_W-1:0] result_c,
   input  logic [`WB_ADDR_W-1:0] neip,
   input  logic [`WB_ADDR_W-1:0] neip_not_taken,
   input  logic [`WB_SEL_W-1:0]  ncs,
   input  logic [`WB_DATA_W-1:0] flags_fwd,
   output logic [`WB_DATA_W-1:0] data1,
   output logic [`WB_ADDR_W-1:0] eip,
   output logic [`WB_SEL_W-1:0]  cs,
   output logic [`WB_DATA_W-1:0] saved_count,
   wb_ctrl_if.opsel              ctl
);
   logic [`WB_ADDR_W-1:0] saved_eip;
   logic [`WB_SEL_W-1:0]  saved_cs;

   // pushf stores the live flags
   assign data1 = ctl.push_flags ? flags_fwd : result_a;

   always_comb begin
      if (ctl.use_temp_neip) begin
         eip = saved_eip;
      end else if (ctl.take_not_taken) begin
         eip = neip_not_taken;
      end else begin
         eip = neip;
      end
   end

   assign cs = ctl.use_temp_ncs ? saved_cs : ncs;

   // saved state for far transfers and string loops
   always_ff @(posedge clk) begin
      if (reset) begin
         saved_eip <= '0;
         saved_cs <= '0;
         saved_count <= '0;
      end else if (ctl.commit) begin
         if (ctl.save_neip) begin
            saved_eip <= neip;
         end
         if (ctl.save_ncs) begin
            saved_cs <= ncs;
         end
         if (ctl.save_count) begin
            saved_count <= result_c;
         end
      end
   end
endmodule

// ==== rtl/wb_apb_store.sv ====
`include "wb_consts.svh"

module wb_apb_store (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  store_req,
   input  logic [`WB_ADDR_W-1:0] address,
   input  logic [`WB_DATA_W-1:0] data1,
   input  logic [`WB_MM_W-1:0]   result_mm,
   input  logic                  mm_mem,
   input  logic [`WB_MM_W-1:0]   prdata,
   input  logic                  pready,
   input  logic                  pslverr,
   output logic                  store_done,
   output logic                  psel,
   output logic                  penable,
   output logic                  pwrite,
   output logic [`WB_ADDR_W-1:0] paddr,
   output logic [`WB_MM_W-1:0]   pwdata
);
   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } state_e;

   state_e state;
   logic [`WB_MM_W-1:0] store_data;

   assign store_data = mm_mem ? result_mm : {{(`WB_MM_W-`WB_DATA_W){1'b0}}, data1};

   assign psel = (state != IDLE);
   assign penable = (state == ACCESS);
   assign pwrite = 1'b1;
   assign store_done = (state == ACCESS) & pready;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: if (store_req) state <= SETUP;
            SETUP: state <= ACCESS;
            ACCESS: begin
               // no retry on a slave error
               if (pready) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // payload captured when the transfer opens
   always_ff @(posedge clk) begin
      if (state == IDLE && store_req) begin
         paddr <= address;
         pwdata <= store_data;
      end
   end
endmodule

// ==== rtl/wb_stage.sv ====
`include "wb_consts.svh"

module wb_stage (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   wb_v,
   input  wb_pkg::uop_ctrl_t      uop,
   input  logic [`WB_SIZE_W-1:0]  datasize,
   input  logic                   ex_ld_gpr1,
   input  logic                   ex_ld_gpr2,
   input  logic                   d2_ld_mm,
   input  logic                   ex_dcache_write,
   input  logic                   d2_repne,
   input  logic [2:0]             dr1,
   input  logic [2:0]             dr2,
   input  logic [`WB_DATA_W-1:0]  result_a,
   input  logic [`WB_DATA_W-1:0]  result_b,
   input  logic [`WB_DATA_W-1:0]  result_c,
   input  logic [`WB_MM_W-1:0]    result_mm,
   input  logic [`WB_DATA_W-1:0]  flags_in,
   input  logic [`WB_ADDR_W-1:0]  neip,
   input  logic [`WB_ADDR_W-1:0]  neip_not_taken,
   input  logic [`WB_SEL_W-1:0]   ncs,
   input  logic [`WB_ADDR_W-1:0]  address,
   input  logic [`WB_MM_W-1:0]    prdata,
   input  logic                   pready,
   input  logic                   pslverr,
   output logic [2:0]             final_dr1,
   output logic [2:0]             final_dr2,
   output logic [2:0]             final_dr3,
   output logic [`WB_DATA_W-1:0]  final_data1,
   output logic [`WB_DATA_W-1:0]  final_data2,
   output logic [`WB_DATA_W-1:0]  final_data3,
   output logic                   ld_gpr1,
   output logic                   ld_gpr2,
   output logic                   ld_gpr3,
   output logic [`WB_SIZE_W-1:0]  final_datasize,
   output logic [`WB_SIZE_W-1:0]  dr3_datasize,
   output logic                   ld_seg,
   output logic [`WB_MM_W-1:0]    mm_data,
   output logic                   ld_mm,
   output logic [`WB_ADDR_W-1:0]  eip,
   output logic                   ld_eip,
   output logic [`WB_SEL_W-1:0]   cs,
   output logic                   ld_cs,
   output logic [`WB_DATA_W-1:0]  flags,
   output logic                   ld_flags,
   output logic                   psel,
   output logic                   penable,
   output logic                   pwrite,
   output logic [`WB_ADDR_W-1:0]  paddr,
   output logic [`WB_MM_W-1:0]    pwdata,
   output logic                   dep_ld_gpr1,
   output logic                   dep_ld_gpr2,
   output logic                   dep_ld_gpr3,
   output logic                   dep_ld_seg,
   output logic                   dep_ld_mm,
   output logic                   dep_dcache_write,
   output logic                   halt,
   output logic                   repne_terminate,
   output logic                   stall,
   output logic                   branch_taken,
   output logic [`WB_DATA_W-1:0]  flags_fwd,
   output logic [`WB_DATA_W-1:0]  saved_count
);
   logic store_req;
   logic store_done;
   logic [`WB_DATA_W-1:0] data1;

   wb_ctrl_if ctl_if ();

   wb_control u_control (
      .wb_v(wb_v), .uop(uop),
      .ex_ld_gpr1(ex_ld_gpr1), .ex_ld_gpr2(ex_ld_gpr2), .d2_ld_mm(d2_ld_mm),
      .ex_dcache_write(ex_dcache_write), .d2_repne(d2_repne),
      .dr1(dr1), .dr2(dr2), .result_c(result_c), .store_done(store_done),
      .store_req(store_req), .stall(stall),
      .final_dr1(final_dr1), .final_dr2(final_dr2),
      .ld_gpr1(ld_gpr1), .ld_gpr2(ld_gpr2), .ld_gpr3(ld_gpr3),
      .ld_seg(ld_seg), .ld_mm(ld_mm), .ld_eip(ld_eip), .ld_cs(ld_cs),
      .ld_flags(ld_flags),
      .dep_ld_gpr1(dep_ld_gpr1), .dep_ld_gpr2(dep_ld_gpr2), .dep_ld_gpr3(dep_ld_gpr3),
      .dep_ld_seg(dep_ld_seg), .dep_ld_mm(dep_ld_mm), .dep_dcache_write(dep_dcache_write),
      .halt(halt), .repne_terminate(repne_terminate), .branch_taken(branch_taken),
      .ctl(ctl_if.ctrl)
   );

   wb_flags_unit u_flags (
      .clk(clk), .reset(reset), .flags_in(flags_in), .result_a(result_a),
      .flags_fwd(flags_fwd), .ctl(ctl_if.flags)
   );

   wb_operand_select u_opsel (
      .clk(clk), .reset(reset), .result_a(result_a), .result_c(result_c),
      .neip(neip), .neip_not_taken(neip_not_taken), .ncs(ncs), .flags_fwd(flags_fwd),
      .data1(data1), .eip(eip), .cs(cs), .saved_count(saved_count),
      .ctl(ctl_if.opsel)
   );

   wb_apb_store u_store (
      .clk(clk), .reset(reset), .store_req(store_req), .address(address),
      .data1(data1), .result_mm(result_mm), .mm_mem(uop.mm_mem),
      .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .store_done(store_done), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata)
   );

   assign final_dr3 = uop.dr3;
   assign final_data1 = data1;
   assign final_data2 = result_b;
   assign final_data3 = result_c;
   assign final_datasize = datasize;
   assign dr3_datasize = `WB_DR3_SIZE;
   assign mm_data = result_mm;
   assign flags = flags_fwd;
endmodule

// ==== bench/wb_stage_checker.sv ====
`include "wb_consts.svh"

module wb_stage_checker (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  active,
   input  logic                  done,
   input  int                    row_idx,
   input  logic                  stall,
   input  logic                  ld_gpr1,
   input  logic                  ld_gpr2,
   input  logic                  ld_gpr3,
   input  logic                  ld_seg,
   input  logic                  ld_mm,
   input  logic                  ld_eip,
   input  logic                  ld_cs,
   input  logic                  ld_flags,
   input  logic                  dep_ld_gpr1,
   input  logic                  dep_ld_gpr2,
   input  logic                  dep_ld_gpr3,
   input  logic                  dep_ld_seg,
   input  logic                  dep_ld_mm,
   input  logic                  dep_dcache_write,
   input  logic [2:0]            final_dr1,
   input  logic [2:0]            final_dr2,
   input  logic [2:0]            final_dr3,
   input  logic [`WB_DATA_W-1:0] final_data1,
   input  logic [`WB_DATA_W-1:0] final_data2,
   input  logic [`WB_DATA_W-1:0] final_data3,
   input  logic [`WB_SIZE_W-1:0] final_datasize,
   input  logic [`WB_SIZE_W-1:0] dr3_datasize,
   input  logic [`WB_MM_W-1:0]   mm_data,
   input  logic [`WB_ADDR_W-1:0] eip,
   input  logic [`WB_SEL_W-1:0]  cs,
   input  logic [`WB_DATA_W-1:0] flags,
   input  logic [`WB_DATA_W-1:0] flags_fwd,
   input  logic                  halt,
   input  logic                  repne_terminate,
   input  logic                  branch_taken,
   input  logic [`WB_DATA_W-1:0] saved_count,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic                  pready,
   input  logic [`WB_ADDR_W-1:0] paddr,
   input  logic [`WB_MM_W-1:0]   pwdata,
   input  logic [`WB_DATA_W-1:0] result_b,
   input  logic [`WB_DATA_W-1:0] result_c,
   input  logic [`WB_MM_W-1:0]   result_mm,
   input  logic [`WB_SIZE_W-1:0] datasize,
   input  logic [`WB_SEL_W-1:0]  ncs,
   input  logic [7:0]            exp_ld,
   input  logic [8:0]            exp_dr,
   input  logic [`WB_DATA_W-1:0] exp_data1,
   input  logic [`WB_ADDR_W-1:0] exp_eip,
   input  logic [`WB_DATA_W-1:0] exp_flags,
   input  logic [`WB_DATA_W-1:0] exp_count,
   input  logic [2:0]            exp_misc,
   input  logic                  exp_store,
   input  logic [`WB_ADDR_W-1:0] exp_paddr,
   input  logic [`WB_MM_W-1:0]   exp_wdata,
   output int                    err_count,
   output int                    row_count
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [7:0] lds;
   logic [4:0] deps;
   logic setup_seen;
   logic row_bad;

   assign lds = {ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, ld_eip, ld_cs, ld_flags};
   assign deps = {dep_ld_gpr1, dep_ld_gpr2, dep_ld_gpr3, dep_ld_seg, dep_ld_mm};

   initial begin
      err_count = 0;
      row_count = 0;
      setup_seen = 1'b0;
      row_bad = 1'b0;
   end

   task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("error %0d ns: row %0d %s got %0h expected %0h",
                  $time, row_idx, what, got, exp);
         err_count++;
         row_bad = 1'b1;
      end
   endtask

   always @(negedge clk) begin
      if (!reset && active) begin
         if (stall) begin
            compare("load enables while stalled", lds, 8'h00);
            if (psel && !penable) begin
               setup_seen = 1'b1;
            end else if (psel && penable && !setup_seen) begin
               $display("row %0d: APB access phase began without a setup phase", row_idx);
               err_count++;
               row_bad = 1'b1;
            end
         end else begin
            compare("load enables", lds, exp_ld);
            compare("dependency bits", {deps, dep_dcache_write}, {exp_ld[7:3], exp_store});
            compare("register numbers", {final_dr1, final_dr2, final_dr3}, exp_dr);
            compare("data1", final_data1, exp_data1);
            compare("data2", final_data2, result_b);
            compare("data3", final_data3, result_c);
            compare("data sizes", {final_datasize, dr3_datasize}, {datasize, `WB_DR3_SIZE});
            compare("mm data", mm_data, result_mm);
            compare("eip", eip, exp_eip);
            compare("cs", cs, ncs);
            compare("flags", flags, exp_flags);
            compare("flags_fwd", flags_fwd, exp_flags);
            compare("saved count", saved_count, exp_count);
            compare("halt/terminate/branch", {halt, repne_terminate, branch_taken}, exp_misc);
            if (exp_store) begin
               // the commit cycle is the access cycle with pready
               compare("APB psel/penable/pwrite/pready", {psel, penable, pwrite, pready},
                       4'b1111);
               compare("paddr", paddr, exp_paddr);
               compare("pwdata", pwdata, exp_wdata);
               if (!setup_seen) begin
                  $display("row %0d: store completed without a setup phase", row_idx);
                  err_count++;
                  row_bad = 1'b1;
               end
            end
            row_count++;
            $display("row %0d %s", row_idx, row_bad ? "failed" : "ok");
            setup_seen = 1'b0;
            row_bad = 1'b0;
         end
      end
   end

   always @(posedge done) begin
      $display("%0d rows checked, %0d errors", row_count, err_count);
   end
endmodule

// ==== bench/wb_stage_tb.sv ====
`include "wb_consts.svh"

module wb_stage_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NROWS = 14;

   typedef struct packed {
      logic v;
      wb_pkg::uop_ctrl_t uop;
      // ex_ld_gpr1, ex_ld_gpr2, d2_ld_mm, ex_dcache_write, d2_repne
      logic [4:0] req;
      logic [31:0] res_a;
      logic [31:0] res_c;
      logic [31:0] fin;
      logic [31:0] addr;
      logic [63:0] mm;
      logic [7:0] e_ld;
      logic [31:0] e_data1;
      logic [31:0] e_eip;
      logic [31:0] e_flags;
      logic [31:0] e_count;
      logic [2:0] e_misc;
      logic [63:0] e_wdata;
   } row_t;

   logic clk = 1'b0;
   logic reset, wb_v, ex_ld_gpr1, ex_ld_gpr2, d2_ld_mm, ex_dcache_write, d2_repne;
   logic pready, pslverr;
   wb_pkg::uop_ctrl_t uop;
   logic [`WB_SIZE_W-1:0] datasize, final_datasize, dr3_datasize;
   logic [2:0] dr1, dr2, final_dr1, final_dr2, final_dr3;
   logic [`WB_DATA_W-1:0] result_a, result_b, result_c, flags_in;
   logic [`WB_DATA_W-1:0] final_data1, final_data2, final_data3, flags, flags_fwd, saved_count;
   logic [`WB_MM_W-1:0] result_mm, prdata, mm_data, pwdata;
   logic [`WB_ADDR_W-1:0] neip, neip_not_taken, address, eip, paddr;
   logic [`WB_SEL_W-1:0] ncs, cs;
   logic ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, ld_eip, ld_cs, ld_flags;
   logic psel, penable, pwrite, halt, repne_terminate, stall, branch_taken;
   logic dep_ld_gpr1, dep_ld_gpr2, dep_ld_gpr3, dep_ld_seg, dep_ld_mm, dep_dcache_write;
   logic active, done, exp_store;
   int row_idx, err_count, row_count;
   logic [7:0] exp_ld;
   logic [8:0] exp_dr;
   logic [2:0] exp_misc;
   logic [31:0] exp_data1, exp_eip, exp_flags, exp_count, exp_paddr;
   logic [63:0] exp_wdata;
   row_t rows[NROWS];
   logic [7:0] lfsr = 8'd61;
   logic [1:0] wait_n, waits_left;

   wb_stage u_dut (.*);
   wb_stage_checker u_chk (.*);

   always #50 clk = ~clk;

   // taps 8,6,5,4
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   // APB completer with 0 to 3 wait states
   always @(posedge clk) begin
      if (reset) begin
         pready <= 1'b0;
      end else if (psel && !penable) begin
         lfsr = lfsr_step(lfsr);
         wait_n[0] = lfsr[0];
         lfsr = lfsr_step(lfsr);
         wait_n[1] = lfsr[0];
         waits_left <= wait_n;
         pready <= (wait_n == 2'd0);
      end else if (psel && penable && !pready) begin
         waits_left <= waits_left - 2'd1;
         pready <= (waits_left == 2'd1);
      end else begin
         pready <= 1'b0;
      end
   end

   initial begin
      #((NROWS * 6 + 5 + 3) * 100);
      $display("timeout: the stage did not finish all rows in time");
      $display("Result: FAILED");
      $finish;
   end

   function automatic row_t mk(input logic v, input logic [17:0] c, input logic [31:0] aff,
                               input logic [4:0] req, input logic [31:0] ra, input logic [31:0] rc,
                               input logic [31:0] fi, input logic [31:0] ad,
                               input logic [63:0] mm, input logic [7:0] el,
                               input logic [31:0] ed, input logic [31:0] ee,
                               input logic [31:0] ef, input logic [31:0] ec,
                               input logic [2:0] em, input logic [63:0] ew);
      return {v, c, 3'd5, aff, req, ra, rc, fi, ad, mm, el, ed, ee, ef, ec, em, ew};
   endfunction

   task automatic apply_row(input int i);
      row_t r;
      r = rows[i];
      wb_v <= r.v;
      uop <= r.uop;
      {ex_ld_gpr1, ex_ld_gpr2, d2_ld_mm, ex_dcache_write, d2_repne} <= r.req;
      result_a <= r.res_a;
      result_b <= r.res_a + 32'd1;
      result_c <= r.res_c;
      result_mm <= r.mm;
      flags_in <= r.fin;
      address <= r.addr;
      neip <= 32'h1000 + 4 * i;
      neip_not_taken <= 32'h2000 + 4 * i;
      exp_ld <= r.e_ld;
      // second cmps micro-op writes dr2 and dr1 in swapped order
      exp_dr <= r.uop.is_cmps_second ? {3'd2, 3'd1, 3'd5} : {3'd1, 3'd2, 3'd5};
      exp_data1 <= r.e_data1;
      exp_eip <= r.e_eip;
      exp_flags <= r.e_flags;
      exp_count <= r.e_count;
      exp_misc <= r.e_misc;
      exp_store <= r.v & r.req[1];
      exp_paddr <= r.addr;
      exp_wdata <= r.e_wdata;
      row_idx <= i;
      active <= 1'b1;
   endtask

   initial begin
      reset = 1'b1;
      {wb_v, ex_ld_gpr1, ex_ld_gpr2, d2_ld_mm, ex_dcache_write, d2_repne} = '0;
      uop = '0;
      {datasize, dr1, dr2, ncs} = {2'b10, 3'd1, 3'd2, 16'h0008};
      {result_a, result_b, result_c, flags_in, result_mm, prdata} = '0;
      {neip, neip_not_taken, address, pslverr, pready} = '0;
      {active, done, row_idx, exp_store} = '0;
      // ctrl bits: halt jne jnbe cmovc cmps1 cmps2 _ gpr3 seg flags eip cs pop
      //            _ push sneip sncs tneip tncs mm
      // expected ld: gpr1 gpr2 gpr3 seg mm eip cs flags; misc: halt term branch
      rows[0] = mk(1, 18'b000000_110110_000000, 0, 5'b11100, 32'h11, 32'h33, 0, 0,
                   64'h55, 8'b11111110, 32'h11, 32'h1000, 32'h2, 0, 3'b000, 0);
      rows[1] = mk(0, 18'b000000_110110_000000, 0, 5'b11110, 32'h22, 0, 0, 0,
                   0, 8'b00000000, 32'h22, 32'h1004, 32'h2, 0, 3'b000, 0);
      rows[2] = mk(1, 18'b000000_001000_000000, 32'h41, 0, 32'h22, 0, 32'hffff_ffff, 0,
                   0, 8'b00000001, 32'h22, 32'h1008, 32'h43, 0, 3'b000, 0);
      rows[3] = mk(1, 18'b010000_000100_000000, 0, 0, 0, 0, 0, 0,
                   0, 8'b00000100, 0, 32'h200c, 32'h43, 0, 3'b000, 0);
      rows[4] = mk(1, 18'b001100_000100_000000, 0, 5'b01000, 0, 0, 0, 0,
                   0, 8'b01000100, 0, 32'h2010, 32'h43, 0, 3'b000, 0);
      rows[5] = mk(1, 18'b000000_001001_000000, 0, 0, 32'h2, 0, 0, 0,
                   0, 8'b00000001, 32'h2, 32'h1014, 32'h2, 0, 3'b000, 0);
      rows[6] = mk(1, 18'b010100_000100_100000, 0, 5'b01000, 32'h77, 0, 0, 0,
                   0, 8'b00000100, 32'h2, 32'h1018, 32'h2, 0, 3'b001, 0);
      rows[7] = mk(1, 18'b001000_000100_000000, 0, 0, 0, 0, 0, 0,
                   0, 8'b00000100, 0, 32'h101c, 32'h2, 0, 3'b001, 0);
      rows[8] = mk(1, 18'b000010_000000_000000, 0, 5'b10000, 0, 32'h5, 0, 0,
                   0, 8'b10000000, 0, 32'h1020, 32'h2, 0, 3'b000, 0);
      rows[9] = mk(1, 18'b000001_000000_000000, 0, 5'b11001, 0, 32'h5, 0, 0,
                   0, 8'b11000000, 0, 32'h1024, 32'h2, 32'h5, 3'b000, 0);
      rows[10] = mk(1, 18'b000001_000000_000000, 0, 5'b11001, 0, 0, 0, 0,
                    0, 8'b00000000, 0, 32'h1028, 32'h2, 32'h5, 3'b010, 0);
      rows[11] = mk(1, 18'b100000_000000_000000, 0, 0, 0, 0, 0, 0,
                    0, 8'b00000000, 0, 32'h102c, 32'h2, 32'h5, 3'b100, 0);
      rows[12] = mk(1, 18'b000000_000000_000000, 0, 5'b10010, 32'hcafe, 0, 0, 32'h8000,
                    0, 8'b10000000, 32'hcafe, 32'h1030, 32'h2, 32'h5, 3'b000, 64'hcafe);
      rows[13] = mk(1, 18'b000000_000000_000001, 0, 5'b00110, 32'h5, 0, 0, 32'h8010,
                    64'h1122334455667788, 8'b00001000, 32'h5, 32'h1034, 32'h2, 32'h5,
                    3'b000, 64'h1122334455667788);
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < NROWS; i++) begin
         @(posedge clk);
         apply_row(i);
         @(negedge clk);
         // inputs stay put until the store completes
         while (stall) @(negedge clk);
      end
      @(posedge clk);
      active <= 1'b0;
      wb_v <= 1'b0;
      @(negedge clk);
      done = 1'b1;
      #1;
      if (err_count == 0 && row_count == NROWS) begin
         $display("Result: PASSED");
      end else begin
         if (row_count != NROWS) begin
            $display("only %0d of %0d rows were checked", row_count, NROWS);
         end
         $display("Result: FAILED");
      end
      $finish;
   end
endmodule

// ==== wb_stage.f ====
+incdir+rtl
rtl/wb_pkg.sv
rtl/wb_ctrl_if.sv
rtl/wb_control.sv
rtl/wb_flags_unit.sv
rtl/wb_operand_select.sv
rtl/wb_apb_store.sv
rtl/wb_stage.sv
bench/wb_stage_checker.sv
bench/wb_stage_tb.sv
